// ==== build.f ====
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/id_slot.sv
rtl/id_stage.sv
rtl/pipe_reg.sv
rtl/halt_ctrl.sv
rtl/decode_frontend.sv
test/decode_frontend_properties.sv
test/decode_frontend_tb.sv

// ==== test/decode_frontend_tb.sv ====
// decode front end testbench
`timescale 1ns/1ps
`default_nettype none

module decode_frontend_tb;

	localparam int          COUNT_W = 32;
	localparam logic [31:0] SEED    = 32'h00dc_41ed;

	logic               clock;
	logic               reset;
	logic               stall;
	id_pkg::fetch_pkt_t fetch_pkt;
	id_pkg::dec_pkt_t   dec_pkt;
	logic               halted;
	logic [COUNT_W-1:0] inst_count;

	id_pkg::dec_pkt_t exp_q [$];     // expected packets in program order
	logic             model_halted;  // halt already accepted
	int unsigned      valid_seen;    // valid slots compared since reset

	decode_frontend #(.COUNT_W(COUNT_W)) dut_i (
		.clock      (clock),
		.reset      (reset),
		.fetch_pkt  (fetch_pkt),
		.stall      (stall),
		.dec_pkt    (dec_pkt),
		.halted     (halted),
		.inst_count (inst_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////////////////////
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		if (got !== exp)
			fail_stop($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference decode
	////////////////////////////////////////////////////////////////////////////
	function automatic id_pkg::dec_slot_t decode_ref(input id_pkg::fetch_slot_t s);
		id_pkg::dec_slot_t d;
		logic [5:0]        op;
		logic [4:0]        ra;
		logic [4:0]        rb;
		logic [4:0]        rc;
		logic              bad;
		op  = s.inst[31:26];
		ra  = s.inst[25:21];
		rb  = s.inst[20:16];
		rc  = s.inst[4:0];
		bad = 1'b0;
		d          = '0;
		d.opa      = {59'd0, ra};   // tags unless an immediate wins
		d.opb      = {59'd0, rb};
		d.dest_idx = id_pkg::ZERO_REG;
		d.alu_func = id_pkg::ALU_ADDQ;
		d.op_type  = op;
		if (s.valid) begin
			if (op >= id_pkg::INTA_GRP && op <= id_pkg::INTM_GRP) begin
				d.dest_idx = rc;
				if (s.inst[12]) begin
					d.opb        = {56'd0, s.inst[20:13]};   // literal
					d.opb_is_val = 1'b1;
				end
				case ({op, s.inst[11:5]})
					{id_pkg::INTA_GRP, id_pkg::ADDQ_FN}:   d.alu_func = id_pkg::ALU_ADDQ;
					{id_pkg::INTA_GRP, id_pkg::SUBQ_FN}:   d.alu_func = id_pkg::ALU_SUBQ;
					{id_pkg::INTA_GRP, id_pkg::CMPEQ_FN}:  d.alu_func = id_pkg::ALU_CMPEQ;
					{id_pkg::INTA_GRP, id_pkg::CMPLT_FN}:  d.alu_func = id_pkg::ALU_CMPLT;
					{id_pkg::INTA_GRP, id_pkg::CMPLE_FN}:  d.alu_func = id_pkg::ALU_CMPLE;
					{id_pkg::INTA_GRP, id_pkg::CMPULT_FN}: d.alu_func = id_pkg::ALU_CMPULT;
					{id_pkg::INTA_GRP, id_pkg::CMPULE_FN}: d.alu_func = id_pkg::ALU_CMPULE;
					{id_pkg::INTL_GRP, id_pkg::AND_FN}:    d.alu_func = id_pkg::ALU_AND;
					{id_pkg::INTL_GRP, id_pkg::BIC_FN}:    d.alu_func = id_pkg::ALU_BIC;
					{id_pkg::INTL_GRP, id_pkg::BIS_FN}:    d.alu_func = id_pkg::ALU_BIS;
					{id_pkg::INTL_GRP, id_pkg::ORNOT_FN}:  d.alu_func = id_pkg::ALU_ORNOT;
					{id_pkg::INTL_GRP, id_pkg::XOR_FN}:    d.alu_func = id_pkg::ALU_XOR;
					{id_pkg::INTL_GRP, id_pkg::EQV_FN}:    d.alu_func = id_pkg::ALU_EQV;
					{id_pkg::INTS_GRP, id_pkg::SRL_FN}:    d.alu_func = id_pkg::ALU_SRL;
					{id_pkg::INTS_GRP, id_pkg::SLL_FN}:    d.alu_func = id_pkg::ALU_SLL;
					{id_pkg::INTS_GRP, id_pkg::SRA_FN}:    d.alu_func = id_pkg::ALU_SRA;
					{id_pkg::INTM_GRP, id_pkg::MULQ_FN}:   d.alu_func = id_pkg::ALU_MULQ;
					default:                               bad = 1'b1;
				endcase
			end else if (op == id_pkg::JSR_GRP) begin
				d.opa        = ~64'h3;   // mask for rb & ~3
				d.opa_is_val = 1'b1;
				d.alu_func   = id_pkg::ALU_AND;
				d.dest_idx   = ra;
				d.uncond_br  = 1'b1;
			end else if (op == id_pkg::LDA_INST || op == id_pkg::LDQ_INST ||
			             op == id_pkg::STQ_INST) begin
				d.opa        = {{48{s.inst[15]}}, s.inst[15:0]};
				d.opa_is_val = 1'b1;
				d.dest_idx   = (op == id_pkg::STQ_INST) ? id_pkg::ZERO_REG : ra;
				d.rd_mem     = (op == id_pkg::LDQ_INST);
				d.wr_mem     = (op == id_pkg::STQ_INST);
			end else if (op[5:3] == 3'b111 || op == id_pkg::BR_INST ||
			             op == id_pkg::BSR_INST) begin
				d.opa        = s.npc;
				d.opa_is_val = 1'b1;
				d.opb        = {{41{s.inst[20]}}, s.inst[20:0], 2'b00};
				d.opb_is_val = 1'b1;
				if (op == id_pkg::BR_INST || op == id_pkg::BSR_INST) begin
					d.dest_idx  = ra;   // link register
					d.uncond_br = 1'b1;
				end else begin
					d.cond_br = 1'b1;
				end
			end else if (op == id_pkg::PAL_INST && s.inst[25:0] == id_pkg::HALT_CODE) begin
				d.halt = 1'b1;
			end else begin
				bad = 1'b1;   // fp, misc, unlisted
			end
		end
		// only the integer path touches fields before turning bad
		if (bad) begin
			d.opb        = {59'd0, rb};
			d.opb_is_val = 1'b0;
			d.dest_idx   = id_pkg::ZERO_REG;
		end
		d.illegal = bad;
		d.valid   = s.valid & ~bad;
		case (op[5:3])
			3'b001, 3'b100, 3'b101: d.fu_sel = id_pkg::FU_MEMORY;
			3'b011, 3'b110, 3'b111: d.fu_sel = id_pkg::FU_BRANCH;
			default: d.fu_sel = (d.alu_func == id_pkg::ALU_MULQ) ? id_pkg::FU_MULTIPLIER
			                                                     : id_pkg::FU_ADDER;
		endcase
		return d;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [12:0] int_enc(input int k);   // {opcode, function}
		case (k)
			0:       return {id_pkg::INTA_GRP, id_pkg::ADDQ_FN};
			1:       return {id_pkg::INTA_GRP, id_pkg::SUBQ_FN};
			2:       return {id_pkg::INTA_GRP, id_pkg::CMPEQ_FN};
			3:       return {id_pkg::INTA_GRP, id_pkg::CMPLT_FN};
			4:       return {id_pkg::INTA_GRP, id_pkg::CMPLE_FN};
			5:       return {id_pkg::INTA_GRP, id_pkg::CMPULT_FN};
			6:       return {id_pkg::INTA_GRP, id_pkg::CMPULE_FN};
			7:       return {id_pkg::INTL_GRP, id_pkg::AND_FN};
			8:       return {id_pkg::INTL_GRP, id_pkg::BIC_FN};
			9:       return {id_pkg::INTL_GRP, id_pkg::BIS_FN};
			10:      return {id_pkg::INTL_GRP, id_pkg::ORNOT_FN};
			11:      return {id_pkg::INTL_GRP, id_pkg::XOR_FN};
			12:      return {id_pkg::INTL_GRP, id_pkg::EQV_FN};
			13:      return {id_pkg::INTS_GRP, id_pkg::SRL_FN};
			14:      return {id_pkg::INTS_GRP, id_pkg::SLL_FN};
			15:      return {id_pkg::INTS_GRP, id_pkg::SRA_FN};
			default: return {id_pkg::INTM_GRP, id_pkg::MULQ_FN};
		endcase
	endfunction

	function automatic logic [31:0] pick_inst(input bit allow_halt);
		logic [31:0] w;
		logic [12:0] enc;
		int          kind;
		int          pick;
		w    = $urandom;   // random fields under the opcode
		kind = $urandom_range(0, 15);
		pick = $urandom_range(0, 9);
		if (kind == 13 && !allow_halt)
			kind = 0;
		case (kind)
			0, 1, 2, 3, 4, 5: begin
				enc       = int_enc($urandom_range(0, 16));
				w[31:26]  = enc[12:7];
				w[11:5]   = enc[6:0];
			end
			6, 7: w[31:26] = (pick < 3) ? id_pkg::LDA_INST :
			                 (pick < 6) ? id_pkg::LDQ_INST : id_pkg::STQ_INST;
			8: w[31:26] = id_pkg::JSR_GRP;
			9, 10: w[31:26] = (pick == 0) ? id_pkg::BR_INST :
			                  (pick == 1) ? id_pkg::BSR_INST : 6'h38 + 6'(pick - 2);
			11: w[31:26] = 6'h31 + 6'(pick % 3);   // fp branches
			12: begin
				w[31:26] = (pick < 3) ? 6'h18 : (pick < 6) ? 6'h16 : id_pkg::INTL_GRP;
				w[11:5]  = 7'h24;                    // cmoveq is not decoded
			end
			13: w = {id_pkg::PAL_INST, id_pkg::HALT_CODE};
			default: ;   // raw word
		endcase
		return w;
	endfunction

	function automatic id_pkg::fetch_pkt_t new_pkt(input bit allow_halt);
		id_pkg::fetch_pkt_t p;
		for (int i = 0; i < 2; i++) begin
			p.slot[i].inst  = pick_inst(allow_halt);
			p.slot[i].npc   = {$urandom, $urandom};
			p.slot[i].valid = ($urandom_range(0, 9) != 0);
		end
		p.present = ($urandom_range(0, 9) != 0);   // some bubbles
		return p;
	endfunction

	// queue what must come out once a packet enters if/id
	task automatic take_pkt(input id_pkg::fetch_pkt_t f);
		id_pkg::dec_pkt_t e;
		if (f.present) begin
			e.present = 1'b1;
			e.slot[0] = decode_ref(f.slot[0]);
			e.slot[1] = decode_ref(f.slot[1]);
			if (e.slot[0].valid && e.slot[0].halt)
				e.slot[1].valid = 1'b0;   // squash behind halt
			if (model_halted) begin
				e.slot[0].valid = 1'b0;
				e.slot[1].valid = 1'b0;
			end
			if ((e.slot[0].valid && e.slot[0].halt) || (e.slot[1].valid && e.slot[1].halt))
				model_halted = 1'b1;
			exp_q.push_back(e);
		end
	endtask

	// fetch holds its packet until an unstalled edge takes it
	task automatic send_pkt(input id_pkg::fetch_pkt_t p);
		int waited;
		bit placed;
		waited = 0;
		placed = 1'b0;
		while (!placed) begin
			@(posedge clock);
			#1;
			if (!stall) begin
				take_pkt(fetch_pkt);
				fetch_pkt = p;
				placed    = 1'b1;
			end
			stall = ($urandom_range(0, 99) < 20);
			waited++;
			if (waited > 50)
				fail_stop("fetch packet was never taken");
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		send_pkt('0);   // last real packet into if/id
		while (exp_q.size() != 0) begin
			@(posedge clock);
			#1;
			stall = ($urandom_range(0, 99) < 20);
			waited++;
			if (waited > 100)
				fail_stop("expected packets never left the DUT");
		end
		stall = 1'b0;
	endtask

	task automatic apply_reset();
		reset     = 1'b1;
		stall     = 1'b0;
		fetch_pkt = '0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		exp_q.delete();
		model_halted = 1'b0;
		valid_seen   = 0;
		check_value("halted", halted, 1'b0);
		check_value("dec_pkt.present", dec_pkt.present, 1'b0);
		check_value("inst_count", inst_count, 0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// comparator pops one packet per exit from id/dispatch
	////////////////////////////////////////////////////////////////////////////
	initial begin
		id_pkg::dec_pkt_t  e;
		id_pkg::dec_slot_t g;
		forever begin
			@(negedge clock);
			if (!reset && dec_pkt.present === 1'b1 && stall === 1'b0) begin
				if (exp_q.size() == 0) begin
					fail_stop("DUT produced a packet that was never sent");
				end else begin
					e = exp_q.pop_front();
					for (int i = 0; i < 2; i++) begin
						g = dec_pkt.slot[i];
						check_value($sformatf("slot%0d.opa", i), g.opa, e.slot[i].opa);
						check_value($sformatf("slot%0d.opa_is_val", i), g.opa_is_val,
						            e.slot[i].opa_is_val);
						check_value($sformatf("slot%0d.opb", i), g.opb, e.slot[i].opb);
						check_value($sformatf("slot%0d.opb_is_val", i), g.opb_is_val,
						            e.slot[i].opb_is_val);
						check_value($sformatf("slot%0d.dest_idx", i), g.dest_idx,
						            e.slot[i].dest_idx);
						check_value($sformatf("slot%0d.alu_func", i), g.alu_func,
						            e.slot[i].alu_func);
						check_value($sformatf("slot%0d.op_type", i), g.op_type, e.slot[i].op_type);
						check_value($sformatf("slot%0d.fu_sel", i), g.fu_sel, e.slot[i].fu_sel);
						check_value($sformatf("slot%0d.rd_mem", i), g.rd_mem, e.slot[i].rd_mem);
						check_value($sformatf("slot%0d.wr_mem", i), g.wr_mem, e.slot[i].wr_mem);
						check_value($sformatf("slot%0d.cond_br", i), g.cond_br, e.slot[i].cond_br);
						check_value($sformatf("slot%0d.uncond_br", i), g.uncond_br,
						            e.slot[i].uncond_br);
						check_value($sformatf("slot%0d.halt", i), g.halt, e.slot[i].halt);
						check_value($sformatf("slot%0d.illegal", i), g.illegal, e.slot[i].illegal);
						check_value($sformatf("slot%0d.valid", i), g.valid, e.slot[i].valid);
						valid_seen += g.valid;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		id_pkg::fetch_pkt_t p;
		reset        = 1'b1;
		stall        = 1'b0;
		fetch_pkt    = '0;
		model_halted = 1'b0;
		valid_seen   = 0;
		void'($urandom(SEED));
		apply_reset();

		// mixed traffic without halts
		repeat (300) send_pkt(new_pkt(1'b0));
		// halt in slot 0 with addq r1 r2 into r3 behind it
		p                = '0;
		p.present        = 1'b1;
		p.slot[0].inst   = {id_pkg::PAL_INST, id_pkg::HALT_CODE};
		p.slot[0].valid  = 1'b1;
		p.slot[1].inst   = {id_pkg::INTA_GRP, 5'd1, 5'd2, 3'b000, 1'b0, id_pkg::ADDQ_FN, 5'd3};
		p.slot[1].npc    = 64'h1008;
		p.slot[1].valid  = 1'b1;
		send_pkt(p);
		repeat (20) send_pkt(new_pkt(1'b0));   // all invalid from here
		drain();
		check_value("halted", halted, 1'b1);
		check_value("inst_count", inst_count, valid_seen);

		// reset clears the halt before traffic with random halts
		apply_reset();
		repeat (200) send_pkt(new_pkt(1'b1));
		drain();
		check_value("halted", halted, model_halted);
		check_value("inst_count", inst_count, valid_seen);

		if (dut_i.props_i.assert_fails == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("%0d assertion failures seen", dut_i.props_i.assert_fails);
			$display("tests failed");
			$fatal(1, "assertion failures during the run");
		end
	end

endmodule

`default_nettype wire

// ==== test/decode_frontend_properties.sv ====
// decode front end assertions
`timescale 1ns/1ps
`default_nettype none

module decode_frontend_properties (
	input wire logic             clock,
	input wire logic             reset,
	input wire logic             stall,
	input wire id_pkg::dec_pkt_t dec_pkt,
	input wire logic             halted
);

	int unsigned assert_fails = 0;   // failed assertion count

	// registers clear on the edge after reset
	reset_clears: assert property (@(posedge clock) reset |=> (!halted && !dec_pkt.present))
		else begin
			assert_fails++;
			$error("halted or present still set after reset");
		end

	// sticky until reset
	halted_sticky: assert property (@(posedge clock) (halted && !reset) |=> halted)
		else begin
			assert_fails++;
			$error("halted fell without reset");
		end

	stall_holds: assert property (@(posedge clock) disable iff (reset)
		stall |=> $stable(dec_pkt))
		else begin
			assert_fails++;
			$error("dec_pkt changed while stalled");
		end

	// illegal slots never issue
	no_valid_illegal: assert property (@(posedge clock) disable iff (reset)
		!(dec_pkt.slot[0].valid && dec_pkt.slot[0].illegal) &&
		!(dec_pkt.slot[1].valid && dec_pkt.slot[1].illegal))
		else begin
			assert_fails++;
			$error("output slot is both valid and illegal");
		end

endmodule

bind decode_frontend decode_frontend_properties props_i (
	.clock   (clock),
	.reset   (reset),
	.stall   (stall),
	.dec_pkt (dec_pkt),
	.halted  (halted)
);

`default_nettype wire

// ==== rtl/decode_frontend.sv ====
// decode front end top level
`timescale 1ns/1ps
`default_nettype none

module decode_frontend #(
	parameter int COUNT_W = 32
) (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire id_pkg::fetch_pkt_t fetch_pkt,   // held by fetch during stall
	input  wire logic               stall,
	output id_pkg::dec_pkt_t        dec_pkt,
	output logic                    halted,
	output logic [COUNT_W-1:0]      inst_count
);

	id_pkg::fetch_pkt_t if_id_pkt;
	id_pkg::dec_pkt_t   id_pkt;
	logic               halt_seen;
	logic [1:0]         issue_n;

	// if/id
	pipe_reg #(.payload_t(id_pkg::fetch_pkt_t)) if_id_reg (
		.clock (clock),
		.reset (reset),
		.stall (stall),
		.d     (fetch_pkt),
		.q     (if_id_pkt)
	);

	id_stage id_stage_i (
		.in_pkt    (if_id_pkt),
		.halted    (halted),
		.stall     (stall),
		.out_pkt   (id_pkt),
		.halt_seen (halt_seen),
		.issue_n   (issue_n)
	);

	halt_ctrl #(.COUNT_W(COUNT_W)) halt_ctrl_i (
		.clock      (clock),
		.reset      (reset),
		.halt_seen  (halt_seen),
		.issue_n    (issue_n),
		.halted     (halted),
		.inst_count (inst_count)
	);

	// id/dispatch
	pipe_reg #(.payload_t(id_pkg::dec_pkt_t)) id_dp_reg (
		.clock (clock),
		.reset (reset),
		.stall (stall),
		.d     (id_pkt),
		.q     (dec_pkt)
	);

endmodule

`default_nettype wire

// ==== rtl/halt_ctrl.sv ====
// halt status and issue counter
`timescale 1ns/1ps
`default_nettype none

module halt_ctrl #(
	parameter int COUNT_W = 32
) (
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic       halt_seen,   // already qualified by present, ~stall
	input  wire logic [1:0] issue_n,     // 0..2 valid slots this edge
	output logic            halted,
	output logic [COUNT_W-1:0] inst_count
);

	// sticky until reset
	always_ff @(posedge clock) begin
		if (reset)
			halted <= 1'b0;
		else if (halt_seen)
			halted <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// issued instruction count, wraps
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset)
			inst_count <= '0;
		else
			inst_count <= inst_count + COUNT_W'(issue_n);   // zero when stalled
	end

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
// stallable pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     stall,   // hold while high
	input  wire payload_t d,
	output payload_t      q
);

	////////////////////////////////////////////////////////////////////////////
	// present bit rides inside the payload
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset)
			q <= '0;   // clears present
		else if (!stall)
			q <= d;
	end

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
// two-wide decode stage
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  wire id_pkg::fetch_pkt_t in_pkt,
	input  wire logic               halted,
	input  wire logic               stall,
	output id_pkg::dec_pkt_t        out_pkt,
	output logic                    halt_seen,
	output logic [1:0]              issue_n
);

	id_pkg::dec_slot_t lane_dec [2];
	logic              accept;   // packet moves into id/dispatch this edge

	for (genvar i = 0; i < 2; i++) begin : g_lane
		id_slot lane_i (
			.slot (in_pkt.slot[i]),
			.dec  (lane_dec[i])
		);
	end

	always_comb begin
		out_pkt.present = in_pkt.present;
		out_pkt.slot[0] = lane_dec[0];
		out_pkt.slot[1] = lane_dec[1];
		if (lane_dec[0].valid && lane_dec[0].halt)
			out_pkt.slot[1].valid = 1'b0;   // squash behind halt
		if (halted) begin
			out_pkt.slot[0].valid = 1'b0;   // machine is stopped
			out_pkt.slot[1].valid = 1'b0;
		end
	end

	assign accept = in_pkt.present & ~stall;

	assign halt_seen = accept & ((out_pkt.slot[0].valid & out_pkt.slot[0].halt) |
	                             (out_pkt.slot[1].valid & out_pkt.slot[1].halt));

	assign issue_n = accept ? 2'(out_pkt.slot[0].valid) + 2'(out_pkt.slot[1].valid) : 2'd0;

endmodule

`default_nettype wire

// ==== rtl/id_slot.sv ====
// one decode lane
`timescale 1ns/1ps
`default_nettype none

module id_slot (
	input  wire id_pkg::fetch_slot_t slot,
	output id_pkg::dec_slot_t        dec
);

	id_pkg::opa_sel_e  opa_sel;
	id_pkg::opb_sel_e  opb_sel;
	id_pkg::dest_sel_e dest_sel;

	// register fields
	logic [4:0] ra, rb, rc;
	assign ra = slot.inst[25:21];
	assign rb = slot.inst[20:16];
	assign rc = slot.inst[4:0];

	// immediates
	logic [63:0] mem_disp, br_disp, alu_imm;
	assign mem_disp = {{48{slot.inst[15]}}, slot.inst[15:0]};
	assign br_disp  = {{41{slot.inst[20]}}, slot.inst[20:0], 2'b00};   // word offset
	assign alu_imm  = {56'd0, slot.inst[20:13]};                       // 8-bit literal

	inst_decoder dec_i (
		.inst      (slot.inst),
		.valid_in  (slot.valid),
		.opa_sel   (opa_sel),
		.opb_sel   (opb_sel),
		.dest_sel  (dest_sel),
		.alu_func  (dec.alu_func),
		.rd_mem    (dec.rd_mem),
		.wr_mem    (dec.wr_mem),
		.cond_br   (dec.cond_br),
		.uncond_br (dec.uncond_br),
		.halt      (dec.halt),
		.illegal   (dec.illegal),
		.valid     (dec.valid)
	);

	assign dec.op_type = slot.inst[31:26];

	////////////////////////////////////////////////////////////////////////////
	// operand and dest muxes
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (opa_sel)
			id_pkg::OPA_IS_MEM_DISP: {dec.opa, dec.opa_is_val} = {mem_disp, 1'b1};
			id_pkg::OPA_IS_NPC:      {dec.opa, dec.opa_is_val} = {slot.npc, 1'b1};
			id_pkg::OPA_IS_NOT3:     {dec.opa, dec.opa_is_val} = {~64'h3, 1'b1};
			default:                 {dec.opa, dec.opa_is_val} = {59'd0, ra, 1'b0};   // tag
		endcase
		case (opb_sel)
			id_pkg::OPB_IS_ALU_IMM: {dec.opb, dec.opb_is_val} = {alu_imm, 1'b1};
			id_pkg::OPB_IS_BR_DISP: {dec.opb, dec.opb_is_val} = {br_disp, 1'b1};
			default:                {dec.opb, dec.opb_is_val} = {59'd0, rb, 1'b0};
		endcase
		case (dest_sel)
			id_pkg::DEST_IS_REGA: dec.dest_idx = ra;
			id_pkg::DEST_IS_REGC: dec.dest_idx = rc;
			default:              dec.dest_idx = id_pkg::ZERO_REG;
		endcase
	end

	// functional unit by opcode group
	always_comb begin
		case ({slot.inst[31:29], 3'b000})
			6'h08, 6'h20, 6'h28: dec.fu_sel = id_pkg::FU_MEMORY;
			6'h18, 6'h30, 6'h38: dec.fu_sel = id_pkg::FU_BRANCH;
			default:
				dec.fu_sel = (dec.alu_func == id_pkg::ALU_MULQ) ? id_pkg::FU_MULTIPLIER
				                                                : id_pkg::FU_ADDER;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
// single instruction decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  wire logic [31:0]    inst,
	input  wire logic           valid_in,   // low -> no-op out
	output id_pkg::opa_sel_e    opa_sel,
	output id_pkg::opb_sel_e    opb_sel,
	output id_pkg::dest_sel_e   dest_sel,
	output id_pkg::alu_func_e   alu_func,
	output logic                rd_mem,
	output logic                wr_mem,
	output logic                cond_br,
	output logic                uncond_br,
	output logic                halt,
	output logic                illegal,
	output logic                valid
);

	assign valid = valid_in & ~illegal;   // halt still counts as valid

	always_comb begin
		// no-op defaults
		opa_sel   = id_pkg::OPA_IS_REGA;
		opb_sel   = id_pkg::OPB_IS_REGB;
		dest_sel  = id_pkg::DEST_NONE;
		alu_func  = id_pkg::ALU_ADDQ;
		rd_mem    = 1'b0;
		wr_mem    = 1'b0;
		cond_br   = 1'b0;
		uncond_br = 1'b0;
		halt      = 1'b0;
		illegal   = 1'b0;
		if (valid_in) begin
			case ({inst[31:29], 3'b000})   // opcode group
				6'h00: begin
					if (inst[31:26] == id_pkg::PAL_INST && inst[25:0] == id_pkg::HALT_CODE)
						halt = 1'b1;
					else
						illegal = 1'b1;   // other pal calls
				end
				6'h10: begin
					// integer operate, literal form on bit 12
					opb_sel  = inst[12] ? id_pkg::OPB_IS_ALU_IMM : id_pkg::OPB_IS_REGB;
					dest_sel = id_pkg::DEST_IS_REGC;
					case (inst[31:26])
						id_pkg::INTA_GRP:
							case (inst[11:5])
								id_pkg::ADDQ_FN:   alu_func = id_pkg::ALU_ADDQ;
								id_pkg::SUBQ_FN:   alu_func = id_pkg::ALU_SUBQ;
								id_pkg::CMPEQ_FN:  alu_func = id_pkg::ALU_CMPEQ;
								id_pkg::CMPLT_FN:  alu_func = id_pkg::ALU_CMPLT;
								id_pkg::CMPLE_FN:  alu_func = id_pkg::ALU_CMPLE;
								id_pkg::CMPULT_FN: alu_func = id_pkg::ALU_CMPULT;
								id_pkg::CMPULE_FN: alu_func = id_pkg::ALU_CMPULE;
								default:           illegal  = 1'b1;
							endcase
						id_pkg::INTL_GRP:
							case (inst[11:5])
								id_pkg::AND_FN:   alu_func = id_pkg::ALU_AND;
								id_pkg::BIC_FN:   alu_func = id_pkg::ALU_BIC;
								id_pkg::BIS_FN:   alu_func = id_pkg::ALU_BIS;
								id_pkg::ORNOT_FN: alu_func = id_pkg::ALU_ORNOT;
								id_pkg::XOR_FN:   alu_func = id_pkg::ALU_XOR;
								id_pkg::EQV_FN:   alu_func = id_pkg::ALU_EQV;
								default:          illegal  = 1'b1;   // cmov etc
							endcase
						id_pkg::INTS_GRP:
							case (inst[11:5])
								id_pkg::SRL_FN: alu_func = id_pkg::ALU_SRL;
								id_pkg::SLL_FN: alu_func = id_pkg::ALU_SLL;
								id_pkg::SRA_FN: alu_func = id_pkg::ALU_SRA;
								default:        illegal  = 1'b1;
							endcase
						id_pkg::INTM_GRP:
							if (inst[11:5] == id_pkg::MULQ_FN)
								alu_func = id_pkg::ALU_MULQ;
							else
								illegal = 1'b1;
						default: illegal = 1'b1;   // fp groups 0x14-0x17
					endcase
				end
				6'h18: begin
					if (inst[31:26] == id_pkg::JSR_GRP) begin
						// target = rb & ~3, link into ra
						opa_sel   = id_pkg::OPA_IS_NOT3;
						alu_func  = id_pkg::ALU_AND;
						dest_sel  = id_pkg::DEST_IS_REGA;
						uncond_br = 1'b1;
					end else begin
						illegal = 1'b1;   // misc, ftpi
					end
				end
				6'h08, 6'h20, 6'h28: begin
					opa_sel = id_pkg::OPA_IS_MEM_DISP;   // ea = disp + rb
					case (inst[31:26])
						id_pkg::LDA_INST: dest_sel = id_pkg::DEST_IS_REGA;
						id_pkg::LDQ_INST: begin
							dest_sel = id_pkg::DEST_IS_REGA;
							rd_mem   = 1'b1;
						end
						id_pkg::STQ_INST: wr_mem  = 1'b1;   // no writeback
						default:          illegal = 1'b1;
					endcase
				end
				6'h30, 6'h38: begin
					opa_sel = id_pkg::OPA_IS_NPC;   // target = npc + disp
					opb_sel = id_pkg::OPB_IS_BR_DISP;
					case (inst[31:26])
						id_pkg::FBEQ_INST, id_pkg::FBLT_INST, id_pkg::FBLE_INST,
						id_pkg::FBNE_INST, id_pkg::FBGE_INST, id_pkg::FBGT_INST:
							illegal = 1'b1;
						id_pkg::BR_INST, id_pkg::BSR_INST: begin
							dest_sel  = id_pkg::DEST_IS_REGA;
							uncond_br = 1'b1;
						end
						default: cond_br = 1'b1;   // integer conditionals
					endcase
				end
				default: illegal = 1'b1;
			endcase
		end
		// illegal words leave as a plain no-op
		if (illegal) begin
			opa_sel   = id_pkg::OPA_IS_REGA;
			opb_sel   = id_pkg::OPB_IS_REGB;
			dest_sel  = id_pkg::DEST_NONE;
			alu_func  = id_pkg::ALU_ADDQ;
			rd_mem    = 1'b0;
			wr_mem    = 1'b0;
			cond_br   = 1'b0;
			uncond_br = 1'b0;
			halt      = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/id_pkg.sv ====
// decode front end shared definitions
`default_nettype none

package id_pkg;

	////////////////////////////////////////////////////////////////////////////
	// major opcodes, inst[31:26]
	////////////////////////////////////////////////////////////////////////////
	localparam logic [5:0] PAL_INST  = 6'h00;
	localparam logic [5:0] LDA_INST  = 6'h08;
	localparam logic [5:0] INTA_GRP  = 6'h10;
	localparam logic [5:0] INTL_GRP  = 6'h11;
	localparam logic [5:0] INTS_GRP  = 6'h12;
	localparam logic [5:0] INTM_GRP  = 6'h13;
	localparam logic [5:0] JSR_GRP   = 6'h1a;   // jmp, jsr, ret, jsr_co
	localparam logic [5:0] LDQ_INST  = 6'h29;
	localparam logic [5:0] STQ_INST  = 6'h2d;
	localparam logic [5:0] BR_INST   = 6'h30;
	localparam logic [5:0] FBEQ_INST = 6'h31;
	localparam logic [5:0] FBLT_INST = 6'h32;
	localparam logic [5:0] FBLE_INST = 6'h33;
	localparam logic [5:0] BSR_INST  = 6'h34;
	localparam logic [5:0] FBNE_INST = 6'h35;
	localparam logic [5:0] FBGE_INST = 6'h36;
	localparam logic [5:0] FBGT_INST = 6'h37;

	// function codes, inst[11:5]
	localparam logic [6:0] ADDQ_FN   = 7'h20;   // inta
	localparam logic [6:0] SUBQ_FN   = 7'h29;
	localparam logic [6:0] CMPEQ_FN  = 7'h2d;
	localparam logic [6:0] CMPLT_FN  = 7'h4d;
	localparam logic [6:0] CMPLE_FN  = 7'h6d;
	localparam logic [6:0] CMPULT_FN = 7'h1d;
	localparam logic [6:0] CMPULE_FN = 7'h3d;
	localparam logic [6:0] AND_FN    = 7'h00;   // intl
	localparam logic [6:0] BIC_FN    = 7'h08;
	localparam logic [6:0] BIS_FN    = 7'h20;
	localparam logic [6:0] ORNOT_FN  = 7'h28;
	localparam logic [6:0] XOR_FN    = 7'h40;
	localparam logic [6:0] EQV_FN    = 7'h48;
	localparam logic [6:0] SRL_FN    = 7'h34;   // ints
	localparam logic [6:0] SLL_FN    = 7'h39;
	localparam logic [6:0] SRA_FN    = 7'h3c;
	localparam logic [6:0] MULQ_FN   = 7'h20;   // intm

	localparam logic [25:0] HALT_CODE = 26'h555;   // pal function field
	localparam logic [4:0]  ZERO_REG  = 5'd31;

	////////////////////////////////////////////////////////////////////////////
	// control selects
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		ALU_ADDQ, ALU_SUBQ, ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT,
		ALU_CMPULE, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
		ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ
	} alu_func_e;

	typedef enum logic [1:0] {OPA_IS_REGA, OPA_IS_MEM_DISP, OPA_IS_NPC, OPA_IS_NOT3} opa_sel_e;
	typedef enum logic [1:0] {OPB_IS_REGB, OPB_IS_ALU_IMM, OPB_IS_BR_DISP} opb_sel_e;
	typedef enum logic [1:0] {DEST_NONE, DEST_IS_REGA, DEST_IS_REGC} dest_sel_e;
	typedef enum logic [1:0] {FU_ADDER, FU_MULTIPLIER, FU_MEMORY, FU_BRANCH} fu_sel_e;

	////////////////////////////////////////////////////////////////////////////
	// packets, slot[0] is first in program order
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [31:0] inst;
		logic [63:0] npc;   // pc + 4
		logic        valid;
	} fetch_slot_t;

	typedef struct packed {
		fetch_slot_t [1:0] slot;
		logic              present;
	} fetch_pkt_t;

	typedef struct packed {
		logic [63:0] opa;
		logic        opa_is_val;   // 1 value, 0 register tag
		logic [63:0] opb;
		logic        opb_is_val;
		logic [4:0]  dest_idx;     // ZERO_REG when no writeback
		alu_func_e   alu_func;
		logic [5:0]  op_type;
		fu_sel_e     fu_sel;
		logic        rd_mem;
		logic        wr_mem;
		logic        cond_br;
		logic        uncond_br;
		logic        halt;
		logic        illegal;
		logic        valid;
	} dec_slot_t;

	typedef struct packed {
		dec_slot_t [1:0] slot;
		logic            present;
	} dec_pkt_t;

endpackage

`default_nettype wire
